// File: oflow_iou_macros.svh
// ------------------------------------------------------------
// overlap-cost block, widths and constants
// corner word layout, fixed point sizes, pipeline timing
// ------------------------------------------------------------
`ifndef OFLOW_IOU_MACROS_SVH
`define OFLOW_IOU_MACROS_SVH

// box geometry
`define COORD_LEN 11
`define DIM_LEN 11
`define BBOX_LEN (4 * `COORD_LEN)

// corner word is {x_tl, y_tl, x_br, y_br}, msb first
`define X_TL_MSB (`BBOX_LEN - 1)
`define Y_TL_MSB (`X_TL_MSB - `COORD_LEN)
`define X_BR_MSB (`Y_TL_MSB - `COORD_LEN)
`define Y_BR_MSB (`X_BR_MSB - `COORD_LEN)

// areas and fixed point result
`define AREA_LEN 22
`define IOU_LEN 22
// quotient carries the 1.0 bit on top of the fraction
`define QUOT_LEN (`IOU_LEN + 1)

// timing
`define MUL_WAIT 3
`define IOU_LATENCY 28
// results allowed in flight to the matcher
`define IOU_CREDITS 2

`endif

// File: oflow_iou_pkg.sv
// ------------------------------------------------------------
// overlap-cost block, shared types
// vector typedefs and controller states
// ------------------------------------------------------------
`include "oflow_iou_macros.svh"

package oflow_iou_pkg;

	// one coordinate of a corner
	typedef logic [`COORD_LEN-1:0] coord_t;
	// box width or height
	typedef logic [`DIM_LEN-1:0] dim_t;
	// packed corner word
	typedef logic [`BBOX_LEN-1:0] bbox_t;
	// box area, intersection, union
	typedef logic [`AREA_LEN-1:0] area_t;
	// cost in q0.22
	typedef logic [`IOU_LEN-1:0] iou_t;
	// divider quotient incl. the 1.0 bit
	typedef logic [`QUOT_LEN-1:0] quot_t;

	// controller states
	typedef enum logic [1:0] {
		idle_st,
		area_st,
		credit_st,
		divide_st
	} iou_state_t;

endpackage

// File: oflow_iou_ctrl.sv
// ------------------------------------------------------------
// overlap-cost controller
// sequences accept, area wait, division and result,
// and holds the credit count toward the matcher
// ------------------------------------------------------------
`timescale 1ns/1ps
`include "oflow_iou_macros.svh"

module oflow_iou_ctrl (
	input  logic clk,
	input  logic reset_N,
	input  logic in_valid,
	input  logic credit_return,
	input  logic timer_done,
	input  logic div_done,
	output logic in_ready,
	output logic load,
	output logic timer_start,
	output logic div_start
);

	localparam int CREDIT_W = $clog2(`IOU_CREDITS + 1);

	oflow_iou_pkg::iou_state_t state;
	oflow_iou_pkg::iou_state_t next_state;

	// credits currently held
	logic [CREDIT_W-1:0] credits;
	logic has_credit;

	assign has_credit = (credits != '0);

	// ------------------------------------------------------------
	// state register
	// ------------------------------------------------------------
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			state <= oflow_iou_pkg::idle_st;
		end else begin
			state <= next_state;
		end
	end

	// ------------------------------------------------------------
	// next state and strobes
	// ------------------------------------------------------------
	always_comb begin
		next_state = state;
		in_ready = 1'b0;
		load = 1'b0;
		timer_start = 1'b0;
		div_start = 1'b0;
		case (state)
			oflow_iou_pkg::idle_st: begin
				in_ready = 1'b1;
				// accept edge, capture boxes and start the wait
				if (in_valid) begin
					load = 1'b1;
					timer_start = 1'b1;
					next_state = oflow_iou_pkg::area_st;
				end
			end
			oflow_iou_pkg::area_st: begin
				// areas settled, launch only with a credit in hand
				if (timer_done) begin
					if (has_credit) begin
						div_start = 1'b1;
						next_state = oflow_iou_pkg::divide_st;
					end else begin
						next_state = oflow_iou_pkg::credit_st;
					end
				end
			end
			oflow_iou_pkg::credit_st: begin
				// stalled by the matcher
				if (has_credit) begin
					div_start = 1'b1;
					next_state = oflow_iou_pkg::divide_st;
				end
			end
			oflow_iou_pkg::divide_st: begin
				if (div_done) begin
					next_state = oflow_iou_pkg::idle_st;
				end
			end
			default: begin
				next_state = oflow_iou_pkg::idle_st;
			end
		endcase
	end

	// ------------------------------------------------------------
	// credit counter
	// ------------------------------------------------------------
	// reserved at launch, returned by the matcher pulse
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			credits <= CREDIT_W'(`IOU_CREDITS);
		end else if (div_start && !credit_return) begin
			credits <= credits - 1'b1;
		end else if (credit_return && !div_start) begin
			// saturate at the reset value
			if (credits != CREDIT_W'(`IOU_CREDITS)) begin
				credits <= credits + 1'b1;
			end
		end
	end

endmodule

// File: oflow_iou_timer.sv
// ------------------------------------------------------------
// multiplier wait timer
// one-cycle done pulse MUL_WAIT cycles after start
// ------------------------------------------------------------
`timescale 1ns/1ps
`include "oflow_iou_macros.svh"

module oflow_iou_timer (
	input  logic clk,
	input  logic reset_N,
	input  logic timer_start,
	output logic timer_done
);

	localparam int CNT_W = $clog2(`MUL_WAIT + 1);

	logic active;
	logic [CNT_W-1:0] count;

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			active <= 1'b0;
			count <= '0;
			timer_done <= 1'b0;
		end else begin
			timer_done <= 1'b0;
			if (timer_start) begin
				// restart from zero
				active <= 1'b1;
				count <= '0;
			end else if (active) begin
				count <= count + 1'b1;
				// last cycle of the wait, pulse and stop
				if (count == CNT_W'(`MUL_WAIT - 1)) begin
					active <= 1'b0;
					timer_done <= 1'b1;
				end
			end
		end
	end

endmodule

// File: oflow_iou_area.sv
// ------------------------------------------------------------
// overlap area unit
// intersection corners, box areas, intersection and union
// over three register stages
// ------------------------------------------------------------
`timescale 1ns/1ps
`include "oflow_iou_macros.svh"

module oflow_iou_area (
	input  logic                  clk,
	input  logic                  reset_N,
	input  logic                  load,
	input  oflow_iou_pkg::bbox_t  bbox_k,
	input  oflow_iou_pkg::bbox_t  bbox_hist,
	input  oflow_iou_pkg::dim_t   w_k,
	input  oflow_iou_pkg::dim_t   h_k,
	input  oflow_iou_pkg::dim_t   w_hist,
	input  oflow_iou_pkg::dim_t   h_hist,
	output oflow_iou_pkg::area_t  inter_area,
	output oflow_iou_pkg::area_t  union_area
);

	// stage 1, captured on load
	oflow_iou_pkg::dim_t w_k_q, h_k_q, w_hist_q, h_hist_q;
	oflow_iou_pkg::coord_t ix_tl, iy_tl, ix_br, iy_br;
	// stage 2
	oflow_iou_pkg::area_t area_k_q, area_hist_q;
	oflow_iou_pkg::dim_t inter_w, inter_h;
	// stage 3 product
	oflow_iou_pkg::area_t inter_prod;

	function automatic oflow_iou_pkg::coord_t max_c(input oflow_iou_pkg::coord_t a,
			input oflow_iou_pkg::coord_t b);
		return (a > b) ? a : b;
	endfunction

	function automatic oflow_iou_pkg::coord_t min_c(input oflow_iou_pkg::coord_t a,
			input oflow_iou_pkg::coord_t b);
		return (a < b) ? a : b;
	endfunction

	// ------------------------------------------------------------
	// stage 1, dims and intersection corners
	// ------------------------------------------------------------
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			w_k_q <= '0;
			h_k_q <= '0;
			w_hist_q <= '0;
			h_hist_q <= '0;
			ix_tl <= '0;
			iy_tl <= '0;
			ix_br <= '0;
			iy_br <= '0;
		end else if (load) begin
			w_k_q <= w_k;
			h_k_q <= h_k;
			w_hist_q <= w_hist;
			h_hist_q <= h_hist;
			// tl is the larger corner, br the smaller
			ix_tl <= max_c(bbox_k[`X_TL_MSB -: `COORD_LEN], bbox_hist[`X_TL_MSB -: `COORD_LEN]);
			iy_tl <= max_c(bbox_k[`Y_TL_MSB -: `COORD_LEN], bbox_hist[`Y_TL_MSB -: `COORD_LEN]);
			ix_br <= min_c(bbox_k[`X_BR_MSB -: `COORD_LEN], bbox_hist[`X_BR_MSB -: `COORD_LEN]);
			iy_br <= min_c(bbox_k[`Y_BR_MSB -: `COORD_LEN], bbox_hist[`Y_BR_MSB -: `COORD_LEN]);
		end
	end

	// ------------------------------------------------------------
	// stage 2 and 3, areas and union
	// ------------------------------------------------------------
	assign inter_prod = inter_w * inter_h;

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			area_k_q <= '0;
			area_hist_q <= '0;
			inter_w <= '0;
			inter_h <= '0;
			inter_area <= '0;
			union_area <= '0;
		end else begin
			area_k_q <= w_k_q * h_k_q;
			area_hist_q <= w_hist_q * h_hist_q;
			// crossed or touching corners, empty overlap
			inter_w <= (ix_br > ix_tl) ? ix_br - ix_tl : '0;
			inter_h <= (iy_br > iy_tl) ? iy_br - iy_tl : '0;
			inter_area <= inter_prod;
			union_area <= area_k_q + area_hist_q - inter_prod;
		end
	end

endmodule

// File: oflow_iou_divider.sv
// ------------------------------------------------------------
// restoring divider for the overlap cost
// (inter << 22) / union, one quotient bit per cycle,
// then cost = all-ones minus the q0.22 ratio
// ------------------------------------------------------------
`timescale 1ns/1ps
`include "oflow_iou_macros.svh"

module oflow_iou_divider (
	input  logic                  clk,
	input  logic                  reset_N,
	input  logic                  div_start,
	input  oflow_iou_pkg::area_t  inter_area,
	input  oflow_iou_pkg::area_t  union_area,
	output logic                  div_done,
	output logic                  cost_valid,
	output oflow_iou_pkg::iou_t   cost
);

	localparam int STEP_W = $clog2(`QUOT_LEN);

	// datapath
	oflow_iou_pkg::area_t divisor;
	oflow_iou_pkg::area_t rem;
	// low dividend bits shift out, quotient bits shift in
	oflow_iou_pkg::quot_t quot;
	// ratio above 1.0 from inconsistent boxes
	logic ovf;
	logic [`AREA_LEN:0] trial;
	logic [`AREA_LEN:0] diff;
	logic fits;

	// control
	logic busy;
	logic fin;
	logic [STEP_W-1:0] step;

	assign trial = {rem, quot[`QUOT_LEN-1]};
	assign diff = trial - {1'b0, divisor};
	assign fits = (trial >= {1'b0, divisor});
	assign div_done = cost_valid;

	// ------------------------------------------------------------
	// step sequencing
	// ------------------------------------------------------------
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			busy <= 1'b0;
			fin <= 1'b0;
			step <= '0;
			cost_valid <= 1'b0;
		end else begin
			fin <= 1'b0;
			cost_valid <= fin;
			if (div_start) begin
				busy <= 1'b1;
				step <= '0;
			end else if (busy) begin
				step <= step + 1'b1;
				if (step == STEP_W'(`QUOT_LEN - 1)) begin
					busy <= 1'b0;
					fin <= 1'b1;
				end
			end
		end
	end

	// ------------------------------------------------------------
	// restoring steps and cost conversion
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (div_start) begin
			divisor <= union_area;
			// top dividend bits seed the remainder
			rem <= inter_area >> 1;
			quot <= {inter_area[0], {`IOU_LEN{1'b0}}};
			ovf <= ((inter_area >> 1) >= union_area);
		end else if (busy) begin
			if (fits) begin
				rem <= diff[`AREA_LEN-1:0];
			end else begin
				rem <= trial[`AREA_LEN-1:0];
			end
			quot <= {quot[`QUOT_LEN-2:0], fits};
		end
		if (fin) begin
			if (divisor == '0) begin
				cost <= '1;
			end else if (ovf || quot[`QUOT_LEN-1]) begin
				// full overlap, no cost
				cost <= '0;
			end else begin
				cost <= {`IOU_LEN{1'b1}} - quot[`IOU_LEN-1:0];
			end
		end
	end

endmodule

// File: oflow_iou_top.sv
// ------------------------------------------------------------
// overlap-cost block top
// controller, wait timer, area unit and divider
// ------------------------------------------------------------
`timescale 1ns/1ps

module oflow_iou_top (
	input  logic                  clk,
	input  logic                  reset_N,
	// request side
	input  logic                  in_valid,
	input  oflow_iou_pkg::bbox_t  bbox_k,
	input  oflow_iou_pkg::bbox_t  bbox_hist,
	input  oflow_iou_pkg::dim_t   w_k,
	input  oflow_iou_pkg::dim_t   h_k,
	input  oflow_iou_pkg::dim_t   w_hist,
	input  oflow_iou_pkg::dim_t   h_hist,
	output logic                  in_ready,
	// result side
	input  logic                  credit_return,
	output logic                  cost_valid,
	output oflow_iou_pkg::iou_t   cost
);

	// ------------------------------------------------------------
	// internal strobes and areas
	// ------------------------------------------------------------
	logic load;
	logic timer_start;
	logic timer_done;
	logic div_start;
	logic div_done;
	oflow_iou_pkg::area_t inter_area;
	oflow_iou_pkg::area_t union_area;

	oflow_iou_ctrl u_ctrl (
		.clk           (clk),
		.reset_N       (reset_N),
		.in_valid      (in_valid),
		.credit_return (credit_return),
		.timer_done    (timer_done),
		.div_done      (div_done),
		.in_ready      (in_ready),
		.load          (load),
		.timer_start   (timer_start),
		.div_start     (div_start)
	);

	// covers the area pipeline after accept
	oflow_iou_timer u_timer (
		.clk         (clk),
		.reset_N     (reset_N),
		.timer_start (timer_start),
		.timer_done  (timer_done)
	);

	oflow_iou_area u_area (
		.clk        (clk),
		.reset_N    (reset_N),
		.load       (load),
		.bbox_k     (bbox_k),
		.bbox_hist  (bbox_hist),
		.w_k        (w_k),
		.h_k        (h_k),
		.w_hist     (w_hist),
		.h_hist     (h_hist),
		.inter_area (inter_area),
		.union_area (union_area)
	);

	oflow_iou_divider u_divider (
		.clk        (clk),
		.reset_N    (reset_N),
		.div_start  (div_start),
		.inter_area (inter_area),
		.union_area (union_area),
		.div_done   (div_done),
		.cost_valid (cost_valid),
		.cost       (cost)
	);

endmodule

// File: oflow_iou_clk_gen.sv
// ------------------------------------------------------------
// testbench clock source, free running
// ------------------------------------------------------------
`timescale 1ns/1ps

module oflow_iou_clk_gen #(
	parameter int PERIOD = 20
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever begin
			#(PERIOD / 2);
			clk = ~clk;
		end
	end

endmodule

// File: oflow_iou_tb.sv
// ------------------------------------------------------------
// testbench for the overlap-cost block
// directed and random box pairs, latency, credit stall
// ------------------------------------------------------------
`timescale 1ns/1ps
`include "oflow_iou_macros.svh"

module oflow_iou_tb;

	localparam int CLK_PERIOD = 20;
	localparam int NUM_PAIRS = 216;
	localparam int MAX_HOLD = 40;
	localparam int WAIT_LIMIT = 200;
	localparam int WATCHDOG_CYCLES = NUM_PAIRS * (`IOU_LATENCY + MAX_HOLD + 4) + 1000;
	localparam int ALL_ONES = (1 << `IOU_LEN) - 1;

	logic clk;
	logic reset_N;
	logic in_valid;
	logic in_ready;
	logic credit_return;
	logic cost_valid;
	oflow_iou_pkg::bbox_t bbox_k;
	oflow_iou_pkg::bbox_t bbox_hist;
	oflow_iou_pkg::dim_t w_k;
	oflow_iou_pkg::dim_t h_k;
	oflow_iou_pkg::dim_t w_hist;
	oflow_iou_pkg::dim_t h_hist;
	oflow_iou_pkg::iou_t cost;
	oflow_iou_pkg::iou_t last_cost;

	integer seed;
	int cyc = 0;
	int outstanding = 0;
	int withheld = 0;
	int hold = 0;
	bit withhold = 0;
	bit check_latency = 0;
	// expected cost and accept cycle per pair, credit due cycles
	oflow_iou_pkg::iou_t exp_q[$];
	int acc_q[$];
	int due[$];

	oflow_iou_clk_gen #(.PERIOD(CLK_PERIOD)) u_clk (.clk(clk));

	oflow_iou_top UUT (
		.clk(clk), .reset_N(reset_N), .in_valid(in_valid), .bbox_k(bbox_k),
		.bbox_hist(bbox_hist), .w_k(w_k), .h_k(h_k), .w_hist(w_hist), .h_hist(h_hist),
		.in_ready(in_ready), .credit_return(credit_return), .cost_valid(cost_valid),
		.cost(cost)
	);

	// ------------------------------------------------------------
	// reference model and helpers
	// ------------------------------------------------------------
	function automatic oflow_iou_pkg::iou_t ref_cost(input oflow_iou_pkg::bbox_t bk,
			input oflow_iou_pkg::bbox_t bh, input int wk, input int hk, input int wh, input int hh);
		int k[4];
		int h[4];
		int iw;
		int ih;
		longint inter;
		longint uni;
		longint q;
		// fields in order x_tl, y_tl, x_br, y_br
		for (int i = 0; i < 4; i++) begin
			k[i] = bk[`X_TL_MSB - i * `COORD_LEN -: `COORD_LEN];
			h[i] = bh[`X_TL_MSB - i * `COORD_LEN -: `COORD_LEN];
		end
		iw = ((k[2] < h[2]) ? k[2] : h[2]) - ((k[0] > h[0]) ? k[0] : h[0]);
		ih = ((k[3] < h[3]) ? k[3] : h[3]) - ((k[1] > h[1]) ? k[1] : h[1]);
		inter = (iw > 0 && ih > 0) ? longint'(iw) * ih : 0;
		uni = longint'(wk) * hk + longint'(wh) * hh - inter;
		if (uni == 0)
			return ALL_ONES;
		q = (inter << `IOU_LEN) / uni;
		// ratio of 1.0 or above means no cost
		if (q >= (longint'(1) << `IOU_LEN))
			return 0;
		return ALL_ONES - q;
	endfunction

	function automatic oflow_iou_pkg::bbox_t box(input int xl, input int yt, input int xr,
			input int yb);
		return {oflow_iou_pkg::coord_t'(xl), oflow_iou_pkg::coord_t'(yt),
			oflow_iou_pkg::coord_t'(xr), oflow_iou_pkg::coord_t'(yb)};
	endfunction

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display(">>> FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic send_boxes(input oflow_iou_pkg::bbox_t bk, input oflow_iou_pkg::bbox_t bh,
			input int wk, input int hk, input int wh, input int hh);
		int waited;
		waited = 0;
		bbox_k = bk;
		bbox_hist = bh;
		w_k = oflow_iou_pkg::dim_t'(wk);
		h_k = oflow_iou_pkg::dim_t'(hk);
		w_hist = oflow_iou_pkg::dim_t'(wh);
		h_hist = oflow_iou_pkg::dim_t'(hh);
		in_valid = 1'b1;
		@(negedge clk);
		while (!in_ready) begin
			waited++;
			assert (waited < WAIT_LIMIT) else report_failure("pair was never accepted");
			@(negedge clk);
		end
		@(posedge clk);
		#1;
		in_valid = 1'b0;
	endtask

	task automatic send_random_pair();
		int x, y, w, h, xh, yh, wh, hh;
		x = $unsigned($random(seed)) % 1000;
		y = $unsigned($random(seed)) % 1000;
		w = 1 + $unsigned($random(seed)) % 400;
		h = 1 + $unsigned($random(seed)) % 400;
		// hist corner inside box k, so the pair overlaps
		xh = x + $unsigned($random(seed)) % w;
		yh = y + $unsigned($random(seed)) % h;
		wh = 1 + $unsigned($random(seed)) % 400;
		hh = 1 + $unsigned($random(seed)) % 400;
		send_boxes(box(x, y, x + w, y + h), box(xh, yh, xh + wh, yh + hh), w, h, wh, hh);
	endtask

	// all results out and all due credits handed back
	task automatic wait_drained();
		int waited;
		waited = 0;
		do begin
			@(posedge clk);
			waited++;
			assert (waited < WAIT_LIMIT) else report_failure("result or credit did not arrive");
		end while (outstanding != 0 || due.size() != 0 || credit_return);
		#1;
	endtask

	task automatic expect_last(input oflow_iou_pkg::iou_t value);
		wait_drained();
		assert (last_cost === value)
			else report_failure($sformatf("** Error: cost = %h, expected %h", last_cost, value));
	endtask

	task automatic return_credits(input int n);
		@(negedge clk);
		#1;
		repeat (n) begin
			due.push_back(cyc);
			withheld--;
		end
		@(posedge clk);
		#1;
	endtask

	// ------------------------------------------------------------
	// matcher model, one credit pulse per due entry
	// ------------------------------------------------------------
	initial begin
		credit_return = 1'b0;
		forever begin
			@(posedge clk);
			#1;
			credit_return = 1'b0;
			if (due.size() != 0 && due[0] <= cyc) begin
				void'(due.pop_front());
				credit_return = 1'b1;
			end
		end
	end

	// ------------------------------------------------------------
	// monitor and comparator, sampled mid-cycle
	// ------------------------------------------------------------
	always @(negedge clk) begin
		oflow_iou_pkg::iou_t want;
		int t_acc;
		cyc = cyc + 1;
		if (reset_N) begin
			if (outstanding > 0)
				assert (!in_ready) else report_failure("in_ready high while a pair is in flight");
			if (cost_valid) begin
				assert (exp_q.size() != 0) else report_failure("cost_valid with no pair in flight");
				want = exp_q.pop_front();
				t_acc = acc_q.pop_front();
				assert (cost === want)
					else report_failure($sformatf("** Error: cost = %h, expected %h", cost, want));
				if (check_latency)
					assert (cyc - t_acc - 1 == `IOU_LATENCY)
						else report_failure("cost_valid came at the wrong cycle after accept");
				last_cost = cost;
				outstanding--;
				if (withhold)
					withheld++;
				else
					due.push_back(cyc + hold);
			end
			if (in_valid && in_ready) begin
				exp_q.push_back(ref_cost(bbox_k, bbox_hist, w_k, h_k, w_hist, h_hist));
				acc_q.push_back(cyc);
				outstanding++;
			end
		end
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("watchdog expired before the test sequence finished");
		$display(">>> FAIL");
		$fatal(1, "timeout");
	end

	// ------------------------------------------------------------
	// test sequence
	// ------------------------------------------------------------
	initial begin
		seed = 32'h055ef924;
		reset_N = 1'b0;
		in_valid = 1'b0;
		bbox_k = '0;
		bbox_hist = '0;
		w_k = '0;
		h_k = '0;
		w_hist = '0;
		h_hist = '0;
		repeat (3) @(posedge clk);
		#1;
		reset_N = 1'b1;
		@(negedge clk);
		assert (in_ready === 1'b1 && cost_valid === 1'b0)
			else report_failure("wrong in_ready or cost_valid after reset");
		@(posedge clk);
		#1;
		// identical, disjoint, touching, zero area
		send_boxes(box(100, 200, 300, 260), box(100, 200, 300, 260), 200, 60, 200, 60);
		expect_last(0);
		send_boxes(box(10, 10, 50, 50), box(100, 100, 150, 140), 40, 40, 50, 40);
		expect_last(ALL_ONES);
		send_boxes(box(10, 10, 50, 50), box(50, 10, 90, 50), 40, 40, 40, 40);
		expect_last(ALL_ONES);
		send_boxes(box(20, 20, 20, 20), box(20, 20, 20, 20), 0, 0, 0, 0);
		expect_last(ALL_ONES);
		// random pairs, second half with a slow matcher
		for (int n = 0; n < 200; n++) begin
			hold = (n >= 100) ? MAX_HOLD : 0;
			send_random_pair();
		end
		wait_drained();
		hold = 0;
		check_latency = 1;
		repeat (8) begin
			send_random_pair();
			wait_drained();
		end
		check_latency = 0;
		// credits withheld, two results then a stall
		withhold = 1;
		repeat (`IOU_CREDITS) begin
			send_random_pair();
			wait_drained();
		end
		send_random_pair();
		in_valid = 1'b1;
		repeat (60) @(posedge clk);
		#1;
		in_valid = 1'b0;
		assert (outstanding == 1 && withheld == `IOU_CREDITS)
			else report_failure("result issued or pair accepted without a credit");
		return_credits(1);
		wait_drained();
		// that credit is spent again, so the next pair stalls
		send_random_pair();
		repeat (60) @(posedge clk);
		#1;
		assert (outstanding == 1 && withheld == `IOU_CREDITS)
			else report_failure("one returned credit released more than one result");
		withhold = 0;
		return_credits(withheld);
		wait_drained();
		$display(">>> PASS");
		$finish;
	end

endmodule

// File: vlog.f
+incdir+.
oflow_iou_pkg.sv
oflow_iou_ctrl.sv
oflow_iou_timer.sv
oflow_iou_area.sv
oflow_iou_divider.sv
oflow_iou_top.sv
oflow_iou_clk_gen.sv
oflow_iou_tb.sv
